// File: beam_pkg.sv
//**********************************************************************
// beam package: coordinate and colour types, host register map,
// default 640x480 raster timing and register reset values
//**********************************************************************
`default_nettype none

package beam_pkg;

    typedef logic [9:0]  coord_t;     // screen position or size, pixels
    typedef logic [2:0]  cfg_addr_t;  // host register address
    typedef logic [15:0] cfg_data_t;  // host write data

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // host register map
    localparam cfg_addr_t REG_SIZE  = 3'd0;  // square size
    localparam cfg_addr_t REG_SPEED = 3'd1;  // pixels per frame
    localparam cfg_addr_t REG_FG    = 3'd2;  // square colour
    localparam cfg_addr_t REG_BG    = 3'd3;  // background colour
    localparam cfg_addr_t REG_CTRL  = 3'd4;  // bit 0 animation enable

    // 640x480 @ 60Hz, 25.175 MHz pixel clock
    localparam int H_ACTIVE_DEF = 640;
    localparam int H_FRONT_DEF  = 16;
    localparam int H_SYNC_DEF   = 96;
    localparam int H_BACK_DEF   = 48;
    localparam int V_ACTIVE_DEF = 480;
    localparam int V_FRONT_DEF  = 10;
    localparam int V_SYNC_DEF   = 2;
    localparam int V_BACK_DEF   = 33;

    // register reset values
    localparam coord_t SIZE_RST  = 10'd32;
    localparam coord_t SPEED_RST = 10'd4;
    localparam rgb_t   FG_RST    = '{r: 4'hD, g: 4'hA, b: 4'h3};  // orange
    localparam rgb_t   BG_RST    = '{r: 4'h3, g: 4'h7, b: 4'hD};  // blue
    localparam logic   ANIM_RST  = 1'b1;

endpackage

`default_nettype wire

// File: display_timings.sv
//**********************************************************************
// display timings: horizontal and vertical raster counters with
// active-low sync pulses and display enable decoded from them
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module display_timings #(
    parameter int H_ACTIVE = beam_pkg::H_ACTIVE_DEF,
    parameter int H_FRONT  = beam_pkg::H_FRONT_DEF,
    parameter int H_SYNC   = beam_pkg::H_SYNC_DEF,
    parameter int H_BACK   = beam_pkg::H_BACK_DEF,
    parameter int V_ACTIVE = beam_pkg::V_ACTIVE_DEF,
    parameter int V_FRONT  = beam_pkg::V_FRONT_DEF,
    parameter int V_SYNC   = beam_pkg::V_SYNC_DEF,
    parameter int V_BACK   = beam_pkg::V_BACK_DEF
) (
    input  wire logic             clk_pix,    // pixel clock
    input  wire logic             rst_n,      // async reset, active low
    output beam_pkg::coord_t      sx,         // horizontal position
    output beam_pkg::coord_t      sy,         // vertical position
    output logic                  hsync_raw,  // active low, unregistered
    output logic                  vsync_raw,  // active low, unregistered
    output logic                  de          // active picture area
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // counter end points
    localparam beam_pkg::coord_t H_LAST = beam_pkg::coord_t'(H_TOTAL - 1);
    localparam beam_pkg::coord_t V_LAST = beam_pkg::coord_t'(V_TOTAL - 1);

    // sync windows, both ends inclusive
    localparam beam_pkg::coord_t HS_FIRST = beam_pkg::coord_t'(H_ACTIVE + H_FRONT);
    localparam beam_pkg::coord_t HS_LAST  =
        beam_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC - 1);
    localparam beam_pkg::coord_t VS_FIRST = beam_pkg::coord_t'(V_ACTIVE + V_FRONT);
    localparam beam_pkg::coord_t VS_LAST  =
        beam_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC - 1);

    // last visible pixel and line + 1
    localparam beam_pkg::coord_t H_END = beam_pkg::coord_t'(H_ACTIVE);
    localparam beam_pkg::coord_t V_END = beam_pkg::coord_t'(V_ACTIVE);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode straight from the counters
    always_comb begin
        hsync_raw = ~((sx >= HS_FIRST) && (sx <= HS_LAST));
        vsync_raw = ~((sy >= VS_FIRST) && (sy <= VS_LAST));
        de        = (sx < H_END) && (sy < V_END);
    end

endmodule

`default_nettype wire

// File: beam_regs.sv
//**********************************************************************
// beam registers: write-only host configuration behind a four-phase
// req/ack handshake, holding square size, speed, colours and enable
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module beam_regs (
    input  wire logic                clk_pix,
    input  wire logic                rst_n,
    input  wire logic                cfg_req,    // host request, held to ack
    input  wire beam_pkg::cfg_addr_t cfg_addr,
    input  wire beam_pkg::cfg_data_t cfg_wdata,
    output logic                     cfg_ack,
    output beam_pkg::coord_t         sq_size,    // never 0
    output beam_pkg::coord_t         sq_speed,
    output beam_pkg::rgb_t           fg,
    output beam_pkg::rgb_t           bg,
    output logic                     anim_en
);

    typedef enum logic {
        S_IDLE,   // waiting for req
        S_ACKED   // ack high, waiting for req to drop
    } state_t;

    state_t state;
    logic   wr_en;   // one cycle per handshake
    logic   size_zero;

    assign wr_en     = cfg_req && (state == S_IDLE);
    assign cfg_ack   = (state == S_ACKED);  // straight from the state flop
    assign size_zero = (cfg_wdata[9:0] == '0);

    // handshake slave
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (cfg_req)  state <= S_ACKED;
                S_ACKED: if (!cfg_req) state <= S_IDLE;  // ack drops next cycle
                default: state <= S_IDLE;
            endcase
        end
    end

    // register file, written on the req edge seen in idle
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sq_size  <= beam_pkg::SIZE_RST;
            sq_speed <= beam_pkg::SPEED_RST;
            fg       <= beam_pkg::FG_RST;
            bg       <= beam_pkg::BG_RST;
            anim_en  <= beam_pkg::ANIM_RST;
        end else if (wr_en) begin
            case (cfg_addr)
                beam_pkg::REG_SIZE:  sq_size  <= size_zero ? 10'd1 : cfg_wdata[9:0];
                beam_pkg::REG_SPEED: sq_speed <= cfg_wdata[9:0];
                beam_pkg::REG_FG:    fg       <= beam_pkg::rgb_t'(cfg_wdata[11:0]);
                beam_pkg::REG_BG:    bg       <= beam_pkg::rgb_t'(cfg_wdata[11:0]);
                beam_pkg::REG_CTRL:  anim_en  <= cfg_wdata[0];
                default: ;  // unmapped, ack only
            endcase
        end
    end

endmodule

`default_nettype wire

// File: square_mover.sv
//**********************************************************************
// square mover: steps the square once per frame at the start of
// vertical blanking, wrapping to the next row and back to the top
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module square_mover #(
    parameter int H_TOTAL  = 800,  // full line incl. blanking
    parameter int V_TOTAL  = 525,  // full frame incl. blanking
    parameter int V_ACTIVE = 480   // first blanking line
) (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire beam_pkg::coord_t sx,
    input  wire beam_pkg::coord_t sy,
    input  wire beam_pkg::coord_t sq_size,
    input  wire beam_pkg::coord_t sq_speed,
    input  wire logic             anim_en,
    output beam_pkg::coord_t      qx,        // top-left corner
    output beam_pkg::coord_t      qy
);

    localparam beam_pkg::coord_t V_BLANK = beam_pkg::coord_t'(V_ACTIVE);

    // edge limits in the 11-bit domain of the sums below
    localparam logic [10:0] H_LIMIT = 11'(H_TOTAL);
    localparam logic [10:0] V_LIMIT = 11'(V_TOTAL);

    logic        frame_tick;  // one clock per frame
    logic [10:0] qx_far;      // qx + size, can exceed 10 bits
    logic [10:0] qy_far;
    logic        x_wrap;
    logic        y_wrap;

    assign frame_tick = anim_en && (sy == V_BLANK) && (sx == '0);

    // qx >= H_TOTAL - size, written as a sum so it never underflows
    assign qx_far = {1'b0, qx} + {1'b0, sq_size};
    assign qy_far = {1'b0, qy} + {1'b0, sq_size};
    assign x_wrap = (qx_far >= H_LIMIT);
    assign y_wrap = (qy_far >= V_LIMIT);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            qx <= '0;
            qy <= '0;
        end else if (frame_tick) begin
            if (x_wrap) begin
                qx <= '0;                           // back to left edge
                qy <= y_wrap ? '0 : qy_far[9:0];    // next row or top
            end else begin
                qx <= qx + sq_speed;
            end
        end
    end

endmodule

`default_nettype wire

// File: pixel_shader.sv
//**********************************************************************
// pixel shader: square hit test and colour select, registered with
// both syncs so colour and sync leave on the same clock
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module pixel_shader (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire beam_pkg::coord_t sx,
    input  wire beam_pkg::coord_t sy,
    input  wire beam_pkg::coord_t qx,
    input  wire beam_pkg::coord_t qy,
    input  wire beam_pkg::coord_t sq_size,
    input  wire beam_pkg::rgb_t   fg,
    input  wire beam_pkg::rgb_t   bg,
    input  wire logic             de,
    input  wire logic             hsync_raw,
    input  wire logic             vsync_raw,
    output logic [3:0]            vga_r,
    output logic [3:0]            vga_g,
    output logic [3:0]            vga_b,
    output logic                  vga_hsync,  // active low
    output logic                  vga_vsync   // active low
);

    logic [10:0]    qx_far;  // right edge, exclusive
    logic [10:0]    qy_far;  // bottom edge, exclusive
    logic           q_hit;
    beam_pkg::rgb_t colour;

    assign qx_far = {1'b0, qx} + {1'b0, sq_size};
    assign qy_far = {1'b0, qy} + {1'b0, sq_size};

    // inside the square at this beam position?
    assign q_hit = (sx >= qx) && ({1'b0, sx} < qx_far)
                && (sy >= qy) && ({1'b0, sy} < qy_far);

    always_comb begin
        if (!de)
            colour = '0;  // black in blanking
        else
            colour = q_hit ? fg : bg;
    end

    // one clock from counters to pins
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
        end else begin
            vga_r     <= colour.r;
            vga_g     <= colour.g;
            vga_b     <= colour.b;
            vga_hsync <= hsync_raw;
            vga_vsync <= vsync_raw;
        end
    end

endmodule

`default_nettype wire

// File: beam_top.sv
//**********************************************************************
// beam top: raster timing, host registers, square mover and shader
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module beam_top #(
    parameter int H_ACTIVE = beam_pkg::H_ACTIVE_DEF,
    parameter int H_FRONT  = beam_pkg::H_FRONT_DEF,
    parameter int H_SYNC   = beam_pkg::H_SYNC_DEF,
    parameter int H_BACK   = beam_pkg::H_BACK_DEF,
    parameter int V_ACTIVE = beam_pkg::V_ACTIVE_DEF,
    parameter int V_FRONT  = beam_pkg::V_FRONT_DEF,
    parameter int V_SYNC   = beam_pkg::V_SYNC_DEF,
    parameter int V_BACK   = beam_pkg::V_BACK_DEF
) (
    input  wire logic                clk_pix,
    input  wire logic                rst_n,
    input  wire logic                cfg_req,
    input  wire beam_pkg::cfg_addr_t cfg_addr,
    input  wire beam_pkg::cfg_data_t cfg_wdata,
    output logic                     cfg_ack,
    output logic [3:0]               vga_r,
    output logic [3:0]               vga_g,
    output logic [3:0]               vga_b,
    output logic                     vga_hsync,
    output logic                     vga_vsync
);

    // full line and frame including blanking
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    beam_pkg::coord_t sx, sy;        // beam position
    logic             hsync_raw, vsync_raw, de;
    beam_pkg::coord_t sq_size, sq_speed;
    beam_pkg::rgb_t   fg, bg;
    logic             anim_en;
    beam_pkg::coord_t qx, qy;        // square corner

    display_timings #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timings (
        .clk_pix, .rst_n, .sx, .sy, .hsync_raw, .vsync_raw, .de
    );

    beam_regs u_regs (
        .clk_pix, .rst_n, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
        .sq_size, .sq_speed, .fg, .bg, .anim_en
    );

    square_mover #(
        .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) u_mover (
        .clk_pix, .rst_n, .sx, .sy, .sq_size, .sq_speed, .anim_en, .qx, .qy
    );

    pixel_shader u_shader (
        .clk_pix, .rst_n, .sx, .sy, .qx, .qy, .sq_size, .fg, .bg,
        .de, .hsync_raw, .vsync_raw,
        .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync
    );

endmodule

`default_nettype wire

// File: beam_checker.sv
//**********************************************************************
// beam checker: bound assertions on the host handshake and on
// blanking of the colour pins during sync
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module beam_checker (
    input wire logic       clk_pix,
    input wire logic       rst_n,
    input wire logic       cfg_req,
    input wire logic       cfg_ack,
    input wire logic [3:0] vga_r,
    input wire logic [3:0] vga_g,
    input wire logic [3:0] vga_b,
    input wire logic       vga_hsync,  // active low
    input wire logic       vga_vsync   // active low
);

    // ack only ever answers a live request, seen on the clock before
    ack_needs_req: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else $error("cfg_ack rose while cfg_req was low");

    // held until the host lets go
    ack_held: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        $fell(cfg_ack) |-> !$past(cfg_req)
    ) else $error("cfg_ack dropped while cfg_req was still high");

    // sync lies in blanking so the pins must be black
    black_in_sync: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (!vga_hsync || !vga_vsync) |-> ({vga_r, vga_g, vga_b} == 12'h000)
    ) else $error("colour pins not black during a sync pulse");

endmodule

`default_nettype wire

// File: beam_tb.sv
//**********************************************************************
// beam testbench: directed tests of the raster engine against a
// reference raster model, with host writes over the req/ack port
//**********************************************************************
`default_nettype none
`timescale 1ns/1ns

module beam_tb;

    // reduced frame keeps runs short
    localparam int H_ACT = 40;
    localparam int H_FP  = 4;
    localparam int H_SW  = 8;
    localparam int H_BP  = 8;
    localparam int V_ACT = 20;
    localparam int V_FP  = 2;
    localparam int V_SW  = 2;
    localparam int V_BP  = 6;
    localparam int H_TOT = H_ACT + H_FP + H_SW + H_BP;  // 60
    localparam int V_TOT = V_ACT + V_FP + V_SW + V_BP;  // 30
    localparam int FRAME = H_TOT * V_TOT;               // clocks per frame
    // tests take about 27 frames, the rest is reset and slack
    localparam int WATCHDOG_FRAMES = 34;

    logic                clk_pix;
    logic                rst_n;
    logic                cfg_req;
    beam_pkg::cfg_addr_t cfg_addr;
    beam_pkg::cfg_data_t cfg_wdata;
    logic                cfg_ack;
    logic [3:0]          vga_r, vga_g, vga_b;
    logic                vga_hsync, vga_vsync;

    // reference model state
    int             m_sx, m_sy;        // raster position
    int             m_qx, m_qy;        // square corner
    int             m_size, m_speed;
    beam_pkg::rgb_t m_fg, m_bg;
    logic           m_anim;
    logic           m_ack;             // host handshake phase
    // expected pins, one clock behind the counters
    beam_pkg::rgb_t exp_rgb;
    logic           exp_hs, exp_vs, exp_de;
    int             exp_x, exp_y;      // pixel now on the pins
    logic [31:0]    lcg_state;

    beam_top #(
        .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP)
    ) DUT (
        .clk_pix, .rst_n, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
        .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync
    );

    bind beam_top beam_checker u_checker (
        .clk_pix, .rst_n, .cfg_req, .cfg_ack,
        .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync
    );

    always #5 clk_pix = ~clk_pix;  // 100 MHz

    always @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            m_sx    <= 0;
            m_sy    <= 0;
            m_qx    <= 0;
            m_qy    <= 0;
            m_size  <= int'(beam_pkg::SIZE_RST);
            m_speed <= int'(beam_pkg::SPEED_RST);
            m_fg    <= beam_pkg::FG_RST;
            m_bg    <= beam_pkg::BG_RST;
            m_anim  <= 1'b1;
            m_ack   <= 1'b0;
            exp_rgb <= '0;    // black, syncs idle high
            exp_hs  <= 1'b1;
            exp_vs  <= 1'b1;
            exp_de  <= 1'b0;
            exp_x   <= 0;
            exp_y   <= 0;
        end else begin
            exp_x  <= m_sx;
            exp_y  <= m_sy;
            exp_de <= (m_sx < H_ACT) && (m_sy < V_ACT);
            exp_hs <= !((m_sx >= H_ACT + H_FP) && (m_sx < H_ACT + H_FP + H_SW));
            exp_vs <= !((m_sy >= V_ACT + V_FP) && (m_sy < V_ACT + V_FP + V_SW));
            if (!((m_sx < H_ACT) && (m_sy < V_ACT)))
                exp_rgb <= '0;
            else if (m_sx >= m_qx && m_sx < m_qx + m_size
                     && m_sy >= m_qy && m_sy < m_qy + m_size)
                exp_rgb <= m_fg;  // inside square
            else
                exp_rgb <= m_bg;
            if (m_sx == H_TOT - 1) begin
                m_sx <= 0;
                m_sy <= (m_sy == V_TOT - 1) ? 0 : m_sy + 1;
            end else begin
                m_sx <= m_sx + 1;
            end
            // one step per frame, first blanking line
            if (m_anim && m_sy == V_ACT && m_sx == 0) begin
                if (m_qx >= H_TOT - m_size) begin
                    m_qx <= 0;
                    m_qy <= (m_qy >= V_TOT - m_size) ? 0 : m_qy + m_size;
                end else begin
                    m_qx <= m_qx + m_speed;
                end
            end
            // write lands on the first clock of a request
            if (cfg_req && !m_ack) begin
                m_ack <= 1'b1;
                case (cfg_addr)
                    beam_pkg::REG_SIZE:
                        m_size <= (cfg_wdata[9:0] == 10'd0) ? 1 : int'(cfg_wdata[9:0]);
                    beam_pkg::REG_SPEED: m_speed <= int'(cfg_wdata[9:0]);
                    beam_pkg::REG_FG:    m_fg    <= beam_pkg::rgb_t'(cfg_wdata[11:0]);
                    beam_pkg::REG_BG:    m_bg    <= beam_pkg::rgb_t'(cfg_wdata[11:0]);
                    beam_pkg::REG_CTRL:  m_anim  <= cfg_wdata[0];
                    default: ;  // unmapped
                endcase
            end else if (m_ack && !cfg_req) begin
                m_ack <= 1'b0;
            end
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic beam_pkg::rgb_t pin_colour();
        return beam_pkg::rgb_t'({vga_r, vga_g, vga_b});
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rgb(input string name, input beam_pkg::rgb_t expected,
                             input beam_pkg::rgb_t actual);
        logic [11:0] e_bits;
        logic [11:0] a_bits;
        e_bits = expected;
        a_bits = actual;
        if (a_bits !== e_bits)
            fail_stop($sformatf("MISMATCH t=%0t %s expected=%03h actual=%03h",
                                $time, name, e_bits, a_bits));
    endtask

    task automatic check_sync(input logic exp_h, input logic exp_v,
                              input logic act_h, input logic act_v);
        if (act_h !== exp_h)
            fail_stop($sformatf("MISMATCH t=%0t vga_hsync expected=%b actual=%b",
                                $time, exp_h, act_h));
        if (act_v !== exp_v)
            fail_stop($sformatf("MISMATCH t=%0t vga_vsync expected=%b actual=%b",
                                $time, exp_v, act_v));
    endtask

    // full four-phase write, returns 1 ns after an edge
    task automatic cfg_write(input beam_pkg::cfg_addr_t addr, input beam_pkg::cfg_data_t data);
        int n;
        @(posedge clk_pix);
        #1;
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_req   = 1'b1;
        n = 0;
        while (cfg_ack !== 1'b1) begin
            @(posedge clk_pix);
            #1;
            n++;
            if (n > 4)
                fail_stop($sformatf("cfg_ack did not rise within 4 cycles, addr %0d", addr));
        end
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack !== 1'b0) begin
            @(posedge clk_pix);
            #1;
            n++;
            if (n > 4)
                fail_stop("cfg_ack stayed high after cfg_req was dropped");
        end
    endtask

    // every pin against the model for n frames
    task automatic run_frames(input int n);
        repeat (n * FRAME) begin
            @(negedge clk_pix);
            check_sync(exp_hs, exp_vs, vga_hsync, vga_vsync);
            check_rgb("vga_rgb", exp_rgb, pin_colour());
        end
    endtask

    task automatic test_sync_blanking();
        repeat (2 * FRAME + 1) begin  // reset cycle plus two frames
            @(negedge clk_pix);
            check_sync(exp_hs, exp_vs, vga_hsync, vga_vsync);
            if (!exp_de)
                check_rgb("vga_rgb blanking", '0, pin_colour());
        end
    endtask

    task automatic test_default_picture();
        repeat (FRAME + 1) begin
            @(negedge clk_pix);
            if (exp_de) begin
                if (exp_x < int'(beam_pkg::SIZE_RST) && exp_y < int'(beam_pkg::SIZE_RST))
                    check_rgb("vga_rgb square", beam_pkg::FG_RST, pin_colour());
                else
                    check_rgb("vga_rgb background", beam_pkg::BG_RST, pin_colour());
            end
        end
    endtask

    task automatic test_cfg_handshake();
        int          size;
        int          speed;
        logic [31:0] rnd_fg;
        logic [31:0] rnd_bg;
        size   = 4 + int'(next_random() % 32'd13);  // 4..16 fits the small frame
        speed  = 1 + int'(next_random() % 32'd7);
        rnd_fg = next_random();
        rnd_bg = next_random();
        cfg_write(beam_pkg::REG_SIZE, 16'(size));
        cfg_write(beam_pkg::REG_SPEED, 16'(speed));
        cfg_write(beam_pkg::REG_FG, {4'h0, rnd_fg[11:0]});
        cfg_write(beam_pkg::REG_BG, {4'h0, rnd_bg[11:0]});
        run_frames(2);
        cfg_write(3'd7, 16'hffff);  // acked, nothing stored
        run_frames(1);
    endtask

    task automatic test_animation_wrap();
        int  prev_qy;
        int  frames;
        bit  wrapped;
        cfg_write(beam_pkg::REG_SIZE, 16'd8);
        cfg_write(beam_pkg::REG_SPEED, 16'd12);
        run_frames(6);  // qx hits the right edge, square drops a row
        cfg_write(beam_pkg::REG_SPEED, 16'd52);  // row every two frames
        prev_qy = m_qy;
        frames  = 0;
        wrapped = 0;
        while (!wrapped) begin
            run_frames(1);
            frames++;
            wrapped = (m_qy < prev_qy);
            prev_qy = m_qy;
            if (!wrapped && frames >= 10)
                fail_stop("square did not wrap back to the top row within 10 frames");
        end
        run_frames(2);  // after the wrap to the top
    endtask

    task automatic test_freeze();
        cfg_write(beam_pkg::REG_CTRL, 16'd0);
        run_frames(2);  // square must hold still
        cfg_write(beam_pkg::REG_CTRL, 16'd1);
        run_frames(2);
    endtask

    initial begin
        #(WATCHDOG_FRAMES * FRAME * 10);
        fail_stop("timeout: watchdog expired before the tests finished");
    end

    initial begin
        clk_pix   = 1'b0;
        rst_n     = 1'b0;
        cfg_req   = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        lcg_state = 32'h30c;
        repeat (8) @(posedge clk_pix);
        #1 rst_n = 1'b1;
        $display("test: sync, blanking and default picture");
        fork
            test_sync_blanking();
            test_default_picture();
        join
        $display("test: configuration handshake");
        test_cfg_handshake();
        $display("test: animation and wrapping");
        test_animation_wrap();
        $display("test: freeze and resume");
        test_freeze();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
beam_pkg.sv
display_timings.sv
beam_regs.sv
square_mover.sv
pixel_shader.sv
beam_top.sv
beam_checker.sv
beam_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the beam testbench with Verilator.
# Exit status is nonzero if the build fails or the testbench stops on $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module beam_tb \
    -f verilog.f \
    -o beam_sim

./obj_dir/beam_sim
